/* design/axi_fabric_pkg.sv */
// ------------------------------------------------------------
// Fabric-wide port definitions
// ------------------------------------------------------------
package axi_fabric_pkg;

  // Upper bound on master or slave ports on one side
  localparam int MAX_PORTS = 16;

  // Index width follows from the port limit
  localparam int PORT_IDX_W = $clog2(MAX_PORTS);

  // Port index within one side of the fabric
  typedef logic [PORT_IDX_W-1:0] port_idx_t;

  // Which side of the fabric a port sits on
  // Master ports drive requests into the fabric
  // Slave ports answer them
  typedef enum logic {
    SIDE_MASTER = 1'b0,
    SIDE_SLAVE  = 1'b1
  } port_side_e;

  // ------------------------------------------------------------
  // Notes on encoding
  // ------------------------------------------------------------
  // One bit is enough for the side, so a request carries
  // side plus index and needs no separate flat port number
  // Flat numbering inside the reset manager puts masters
  // first, then slaves

endpackage : axi_fabric_pkg

/* design/rst_ctrl_pkg.sv */
// ------------------------------------------------------------
// Reset control types
// ------------------------------------------------------------
package rst_ctrl_pkg;

  // Width of a reset duration in clock cycles
  localparam int DUR_W = 8;

  // Reset pulse length in cycles, zero means no pulse
  typedef logic [DUR_W-1:0] duration_t;

  // ------------------------------------------------------------
  // Request payload from the outside world
  // ------------------------------------------------------------
  // 13 bits total
  // Side and index pick the port, duration sets the low time
  typedef struct packed {
    axi_fabric_pkg::port_side_e side;
    axi_fabric_pkg::port_idx_t  port;
    duration_t                  duration;
  } rst_req_t;

  // ------------------------------------------------------------
  // Command from capture stage to one port timer
  // ------------------------------------------------------------
  // Load is a single-cycle strobe
  // Duration is only meaningful while load is high
  typedef struct packed {
    logic      load;
    duration_t duration;
  } timer_load_t;

  // Handy constant for the timer decrement
  localparam duration_t DUR_ONE = duration_t'(1);

  // Zero duration marks an idle timer
  localparam duration_t DUR_ZERO = '0;

endpackage : rst_ctrl_pkg

/* design/rst_request_capture.sv */
`timescale 1ns/1ps

module rst_request_capture #(
  parameter int NUM_MASTERS = 4,
  parameter int NUM_SLAVES  = 4
) (
  input  logic                      aclk,
  input  logic                      inject_global_reset,
  input  logic                      req_valid_i,
  input  rst_ctrl_pkg::rst_req_t    req_i,
  output rst_ctrl_pkg::timer_load_t load_master_o [NUM_MASTERS],
  output rst_ctrl_pkg::timer_load_t load_slave_o  [NUM_SLAVES]
);

  import axi_fabric_pkg::*;
  import rst_ctrl_pkg::*;

  // Masters occupy the low flat indices, slaves follow
  localparam int NUM_PORTS = NUM_MASTERS + NUM_SLAVES;

  logic                 side_is_master;
  logic                 idx_in_range;
  logic                 dur_nonzero;
  logic                 req_ok;
  logic [NUM_PORTS-1:0] load_d;
  logic [NUM_PORTS-1:0] load_q;
  duration_t            dur_q;

  // ------------------------------------------------------------
  // Request validation
  // ------------------------------------------------------------
  assign side_is_master = (req_i.side == SIDE_MASTER);

  // Index must fall inside the configured count for its side
  assign idx_in_range = side_is_master ? (int'(req_i.port) < NUM_MASTERS)
                                       : (int'(req_i.port) < NUM_SLAVES);

  // A zero-length pulse would never show on the outputs
  assign dur_nonzero = (req_i.duration != DUR_ZERO);

  // Only a strobed, in-range, nonzero request reaches a timer
  assign req_ok = req_valid_i && idx_in_range && dur_nonzero;

  // ------------------------------------------------------------
  // Port decode
  // ------------------------------------------------------------
  // One-hot over the flat port space
  // All zero when the request is dropped
  always_comb begin
    load_d = '0;
    for (int m = 0; m < NUM_MASTERS; m++) begin
      if (side_is_master && (int'(req_i.port) == m)) begin
        load_d[m] = req_ok;
      end
    end
    for (int s = 0; s < NUM_SLAVES; s++) begin
      if (!side_is_master && (int'(req_i.port) == s)) begin
        load_d[NUM_MASTERS+s] = req_ok;
      end
    end
  end

  // Strobes are control state and clear on global reset
  always_ff @(posedge aclk) begin
    if (inject_global_reset) begin
      load_q <= '0;
    end else begin
      load_q <= load_d;
    end
  end

  // One shared duration register
  // At most one port loads per cycle, so all timers can share it
  always_ff @(posedge aclk) begin
    if (req_ok) begin
      dur_q <= req_i.duration;
    end
  end

  // ------------------------------------------------------------
  // Per-port load commands
  // ------------------------------------------------------------
  for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_master_load
    assign load_master_o[m] = '{load: load_q[m], duration: dur_q};
  end

  for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave_load
    assign load_slave_o[s] = '{load: load_q[NUM_MASTERS+s], duration: dur_q};
  end

endmodule : rst_request_capture

/* design/rst_port_timer.sv */
`timescale 1ns/1ps

module rst_port_timer (
  input  logic                      aclk,
  input  logic                      inject_global_reset,
  input  rst_ctrl_pkg::timer_load_t load_i,
  output logic                      active_o,
  output logic                      expire_o
);

  import rst_ctrl_pkg::*;

  // Remaining low cycles for this port
  duration_t count_q;

  // Registered end-of-pulse marker
  logic      expire_q;

  // Count reaching one on this edge means the next edge ends the pulse
  logic      last_cycle;

  assign last_cycle = (count_q == DUR_ONE);

  // ------------------------------------------------------------
  // Down counter
  // ------------------------------------------------------------
  // Load wins over decrement, so a reload simply restarts
  // Idle at zero, no wrap
  always_ff @(posedge aclk) begin
    if (inject_global_reset) begin
      count_q <= DUR_ZERO;
    end else if (load_i.load) begin
      count_q <= load_i.duration;
    end else if (count_q != DUR_ZERO) begin
      count_q <= count_q - DUR_ONE;
    end
  end

  // ------------------------------------------------------------
  // Expire pulse
  // ------------------------------------------------------------
  // High for one cycle after the count steps from 1 to 0
  // A load on that same edge keeps the pulse going
  // and so suppresses the expire
  always_ff @(posedge aclk) begin
    if (inject_global_reset) begin
      expire_q <= 1'b0;
    end else begin
      expire_q <= last_cycle && !load_i.load;
    end
  end

  // Active as long as any cycles remain
  assign active_o = (count_q != DUR_ZERO);

  assign expire_o = expire_q;

  // ------------------------------------------------------------
  // Timing summary
  // ------------------------------------------------------------
  // Load at edge L sets count to D
  // Active is high from L through L+D
  // Expire is high in the cycle after edge L+D
  // The output stage turns both into D low cycles of aresetn
  // and a done pulse on the rising edge

endmodule : rst_port_timer

/* design/rst_output_stage.sv */
`timescale 1ns/1ps

module rst_output_stage #(
  parameter int NUM_MASTERS = 4,
  parameter int NUM_SLAVES  = 4
) (
  input  logic                   aclk,
  input  logic                   inject_global_reset,
  input  logic [NUM_MASTERS-1:0] active_master_i,
  input  logic [NUM_MASTERS-1:0] expire_master_i,
  input  logic [NUM_SLAVES-1:0]  active_slave_i,
  input  logic [NUM_SLAVES-1:0]  expire_slave_i,
  output logic [NUM_MASTERS-1:0] aresetn_master_o,
  output logic [NUM_SLAVES-1:0]  aresetn_slave_o,
  output logic [NUM_MASTERS-1:0] done_master_o,
  output logic [NUM_SLAVES-1:0]  done_slave_o
);

  // Both sides handled as one flat vector, masters in the low bits
  localparam int NUM_PORTS = NUM_MASTERS + NUM_SLAVES;

  logic [NUM_PORTS-1:0] active_all;
  logic [NUM_PORTS-1:0] expire_all;
  logic [NUM_PORTS-1:0] aresetn_q;
  logic [NUM_PORTS-1:0] done_q;

  // ------------------------------------------------------------
  // Gather timer status
  // ------------------------------------------------------------
  assign active_all = {active_slave_i, active_master_i};
  assign expire_all = {expire_slave_i, expire_master_i};

  // ------------------------------------------------------------
  // Registered reset and done drivers
  // ------------------------------------------------------------
  // Global reset forces every port low and swallows done pulses
  // Otherwise a port is low exactly while its timer is active
  always_ff @(posedge aclk) begin
    if (inject_global_reset) begin
      aresetn_q <= '0;
      done_q    <= '0;
    end else begin
      aresetn_q <= ~active_all;
      done_q    <= expire_all;
    end
  end

  // Done rises on the same edge as the matching aresetn
  // since both sample the timer in the same cycle

  // ------------------------------------------------------------
  // Split back into per-side outputs
  // ------------------------------------------------------------
  assign aresetn_master_o = aresetn_q[NUM_MASTERS-1:0];
  assign aresetn_slave_o  = aresetn_q[NUM_PORTS-1:NUM_MASTERS];

  assign done_master_o = done_q[NUM_MASTERS-1:0];
  assign done_slave_o  = done_q[NUM_PORTS-1:NUM_MASTERS];

endmodule : rst_output_stage

/* design/axi_reset_manager.sv */
`timescale 1ns/1ps

module axi_reset_manager #(
  parameter int NUM_MASTERS = 4,
  parameter int NUM_SLAVES  = 4
) (
  input  logic                   aclk,
  input  logic                   inject_global_reset,
  input  logic                   req_valid_i,
  input  rst_ctrl_pkg::rst_req_t req_i,
  output logic [NUM_MASTERS-1:0] aresetn_master_o,
  output logic [NUM_SLAVES-1:0]  aresetn_slave_o,
  output logic [NUM_MASTERS-1:0] done_master_o,
  output logic [NUM_SLAVES-1:0]  done_slave_o
);

  import axi_fabric_pkg::*;
  import rst_ctrl_pkg::*;

  // ------------------------------------------------------------
  // Configuration bounds
  // ------------------------------------------------------------
  // Port index is only PORT_IDX_W bits wide
  if ((NUM_MASTERS < 1) || (NUM_MASTERS > MAX_PORTS) ||
      (NUM_SLAVES < 1) || (NUM_SLAVES > MAX_PORTS)) begin : g_bad_cfg
    $error("axi_reset_manager port count out of range 1 to %0d", MAX_PORTS);
  end

  // Capture to timer commands
  timer_load_t            load_master [NUM_MASTERS];
  timer_load_t            load_slave  [NUM_SLAVES];

  // Timer status toward the output stage
  logic [NUM_MASTERS-1:0] active_master;
  logic [NUM_MASTERS-1:0] expire_master;
  logic [NUM_SLAVES-1:0]  active_slave;
  logic [NUM_SLAVES-1:0]  expire_slave;

  // ------------------------------------------------------------
  // Input side
  // ------------------------------------------------------------
  rst_request_capture #(
    .NUM_MASTERS (NUM_MASTERS),
    .NUM_SLAVES  (NUM_SLAVES)
  ) u_capture (
    .aclk                (aclk),
    .inject_global_reset (inject_global_reset),
    .req_valid_i         (req_valid_i),
    .req_i               (req_i),
    .load_master_o       (load_master),
    .load_slave_o        (load_slave)
  );

  // ------------------------------------------------------------
  // One independent timer per port
  // ------------------------------------------------------------
  for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_master_timer
    rst_port_timer u_timer (
      .aclk                (aclk),
      .inject_global_reset (inject_global_reset),
      .load_i              (load_master[m]),
      .active_o            (active_master[m]),
      .expire_o            (expire_master[m])
    );
  end

  for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave_timer
    rst_port_timer u_timer (
      .aclk                (aclk),
      .inject_global_reset (inject_global_reset),
      .load_i              (load_slave[s]),
      .active_o            (active_slave[s]),
      .expire_o            (expire_slave[s])
    );
  end

  // ------------------------------------------------------------
  // Output side
  // ------------------------------------------------------------
  rst_output_stage #(
    .NUM_MASTERS (NUM_MASTERS),
    .NUM_SLAVES  (NUM_SLAVES)
  ) u_output (
    .aclk                (aclk),
    .inject_global_reset (inject_global_reset),
    .active_master_i     (active_master),
    .expire_master_i     (expire_master),
    .active_slave_i      (active_slave),
    .expire_slave_i      (expire_slave),
    .aresetn_master_o    (aresetn_master_o),
    .aresetn_slave_o     (aresetn_slave_o),
    .done_master_o       (done_master_o),
    .done_slave_o        (done_slave_o)
  );

endmodule : axi_reset_manager

/* sim/axi_reset_manager_sva.sv */
`timescale 1ns/1ps

module axi_reset_manager_sva #(
  parameter int NUM_MASTERS = 4,
  parameter int NUM_SLAVES  = 4
) (
  input logic                   aclk,
  input logic                   inject_global_reset,
  input logic                   req_valid_i,
  input rst_ctrl_pkg::rst_req_t req_i,
  input logic [NUM_MASTERS-1:0] aresetn_master_o,
  input logic [NUM_SLAVES-1:0]  aresetn_slave_o,
  input logic [NUM_MASTERS-1:0] done_master_o,
  input logic [NUM_SLAVES-1:0]  done_slave_o
);

  import axi_fabric_pkg::*;
  import rst_ctrl_pkg::*;

  // Flat port order as in the DUT, masters in the low bits
  localparam int NUM_PORTS = NUM_MASTERS + NUM_SLAVES;

  logic [NUM_PORTS-1:0] req_hit;
  logic [NUM_PORTS-1:0] hit_q1;
  logic [NUM_PORTS-1:0] hit_q2;
  duration_t            dur_q1;
  duration_t            dur_q2;
  duration_t            exp_cnt [NUM_PORTS];
  logic [NUM_PORTS-1:0] exp_low;
  logic [NUM_PORTS-1:0] exp_done;
  logic [NUM_PORTS-1:0] exp_aresetn;
  logic                 failed;

  // Simulation starts inside the global reset
  logic rst_q    = 1'b1;
  // Low until the first edge has loaded the DUT output registers
  logic armed    = 1'b0;
  logic fail_rst = 1'b0;
  logic fail_arm = 1'b0;
  logic fail_ars = 1'b0;
  logic fail_dnm = 1'b0;
  logic fail_dns = 1'b0;

  // ------------------------------------------------------------
  // Expected port pulses
  // ------------------------------------------------------------
  // Valid means nonzero duration and an index inside its side
  always_comb begin
    req_hit = '0;
    if (req_valid_i && (req_i.duration != '0)) begin
      for (int m = 0; m < NUM_MASTERS; m++) begin
        if ((req_i.side == SIDE_MASTER) && (int'(req_i.port) == m)) begin
          req_hit[m] = 1'b1;
        end
      end
      for (int s = 0; s < NUM_SLAVES; s++) begin
        if ((req_i.side == SIDE_SLAVE) && (int'(req_i.port) == s)) begin
          req_hit[NUM_MASTERS+s] = 1'b1;
        end
      end
    end
  end

  // Low-cycle count per port, loaded two edges after the strobe
  // Done is expected on the edge where the count runs out
  always @(posedge aclk) begin
    rst_q <= inject_global_reset;
    armed <= 1'b1;
    if (inject_global_reset) begin
      hit_q1   <= '0;
      hit_q2   <= '0;
      exp_done <= '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        exp_cnt[p] <= '0;
      end
    end else begin
      hit_q1 <= req_hit;
      dur_q1 <= req_i.duration;
      hit_q2 <= hit_q1;
      dur_q2 <= dur_q1;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (hit_q2[p]) begin
          exp_cnt[p]  <= dur_q2;
          exp_done[p] <= 1'b0;
        end else if (exp_cnt[p] != '0) begin
          exp_cnt[p]  <= exp_cnt[p] - duration_t'(1);
          exp_done[p] <= (exp_cnt[p] == duration_t'(1));
        end else begin
          exp_done[p] <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      exp_low[p] = (exp_cnt[p] != '0);
    end
  end

  assign exp_aresetn = ~exp_low;

  // Sticky flag for the testbench top
  assign failed = fail_rst | fail_arm | fail_ars | fail_dnm | fail_dns;

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------
  a_reset_outputs : assert property (@(posedge aclk)
    armed && rst_q |-> ((aresetn_master_o == '0) && (aresetn_slave_o == '0) &&
                        (done_master_o == '0) && (done_slave_o == '0)))
    else begin
      fail_rst = 1'b1;
      $error("CHECK FAILED in reset aresetn_master_o %h aresetn_slave_o %h %s %h %s %h",
             $sampled(aresetn_master_o), $sampled(aresetn_slave_o),
             "done_master_o", $sampled(done_master_o),
             "done_slave_o", $sampled(done_slave_o));
    end

  a_aresetn_master : assert property (@(posedge aclk)
    armed && !rst_q |-> (aresetn_master_o == exp_aresetn[NUM_MASTERS-1:0]))
    else begin
      fail_arm = 1'b1;
      $error("CHECK FAILED aresetn_master_o expected %h got %h",
             $sampled(exp_aresetn[NUM_MASTERS-1:0]), $sampled(aresetn_master_o));
    end

  a_aresetn_slave : assert property (@(posedge aclk)
    armed && !rst_q |-> (aresetn_slave_o == exp_aresetn[NUM_PORTS-1:NUM_MASTERS]))
    else begin
      fail_ars = 1'b1;
      $error("CHECK FAILED aresetn_slave_o expected %h got %h",
             $sampled(exp_aresetn[NUM_PORTS-1:NUM_MASTERS]), $sampled(aresetn_slave_o));
    end

  a_done_master : assert property (@(posedge aclk)
    armed && !rst_q |-> (done_master_o == exp_done[NUM_MASTERS-1:0]))
    else begin
      fail_dnm = 1'b1;
      $error("CHECK FAILED done_master_o expected %h got %h",
             $sampled(exp_done[NUM_MASTERS-1:0]), $sampled(done_master_o));
    end

  a_done_slave : assert property (@(posedge aclk)
    armed && !rst_q |-> (done_slave_o == exp_done[NUM_PORTS-1:NUM_MASTERS]))
    else begin
      fail_dns = 1'b1;
      $error("CHECK FAILED done_slave_o expected %h got %h",
             $sampled(exp_done[NUM_PORTS-1:NUM_MASTERS]), $sampled(done_slave_o));
    end

endmodule : axi_reset_manager_sva

bind axi_reset_manager axi_reset_manager_sva #(
  .NUM_MASTERS (NUM_MASTERS),
  .NUM_SLAVES  (NUM_SLAVES)
) u_sva (
  .aclk                (aclk),
  .inject_global_reset (inject_global_reset),
  .req_valid_i         (req_valid_i),
  .req_i               (req_i),
  .aresetn_master_o    (aresetn_master_o),
  .aresetn_slave_o     (aresetn_slave_o),
  .done_master_o       (done_master_o),
  .done_slave_o        (done_slave_o)
);

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 50
) (
  output logic aclk_o
);

  // Free-running fabric clock, 100 ns period by default
  initial begin
    aclk_o = 1'b0;
    forever begin
      #(HALF_PERIOD_NS);
      aclk_o = ~aclk_o;
    end
  end

endmodule : tb_clock_gen

/* sim/tb_axi_reset_manager.sv */
`timescale 1ns/1ps

module tb_axi_reset_manager;

  import axi_fabric_pkg::*;
  import rst_ctrl_pkg::*;

  localparam int NUM_MASTERS  = 4;
  localparam int NUM_SLAVES   = 4;
  localparam int NUM_PORTS    = NUM_MASTERS + NUM_SLAVES;
  localparam int RESET_CYCLES = 16;
  localparam int DRIVE_DELAY  = 10;

  logic                   aclk;
  logic                   inject_global_reset;
  logic                   req_valid;
  rst_req_t               req;
  logic [NUM_MASTERS-1:0] aresetn_master;
  logic [NUM_SLAVES-1:0]  aresetn_slave;
  logic [NUM_MASTERS-1:0] done_master;
  logic [NUM_SLAVES-1:0]  done_slave;
  logic [NUM_PORTS-1:0]   done_all;
  logic [NUM_PORTS-1:0]   done_seen;

  assign done_all = {done_slave, done_master};

  tb_clock_gen u_clk (
    .aclk_o (aclk)
  );

  axi_reset_manager #(
    .NUM_MASTERS (NUM_MASTERS),
    .NUM_SLAVES  (NUM_SLAVES)
  ) DUT (
    .aclk                (aclk),
    .inject_global_reset (inject_global_reset),
    .req_valid_i         (req_valid),
    .req_i               (req),
    .aresetn_master_o    (aresetn_master),
    .aresetn_slave_o     (aresetn_slave),
    .done_master_o       (done_master),
    .done_slave_o        (done_slave)
  );

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  // Advance to just after the next rising edge, outputs are settled here
  task automatic next_cycle();
    @(posedge aclk);
    #(DRIVE_DELAY);
    done_seen = done_seen | done_all;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) next_cycle();
  endtask

  // One-cycle request strobe
  task automatic send_req(input port_side_e req_side, input int port, input int dur);
    req_valid = 1'b1;
    req       = '{side: req_side, port: port_idx_t'(port), duration: duration_t'(dur)};
    next_cycle();
    req_valid = 1'b0;
    req       = '0;
  endtask

  task automatic apply_reset(input int cycles);
    inject_global_reset = 1'b1;
    idle(cycles);
    inject_global_reset = 1'b0;
  endtask

  function automatic logic [NUM_PORTS-1:0] port_mask(input port_side_e side, input int port);
    int flat;
    flat = (side == SIDE_MASTER) ? port : NUM_MASTERS + port;
    return NUM_PORTS'(1) << flat;
  endfunction

  // Wait until every port in the mask has shown a done pulse
  task automatic wait_done(input logic [NUM_PORTS-1:0] mask, input int limit);
    int waited;
    waited = 0;
    while ((done_seen & mask) != mask) begin
      if (waited >= limit) begin
        abort_run($sformatf("Timeout waiting for a done pulse on ports %h",
                            mask & ~done_seen));
      end
      next_cycle();
      waited++;
    end
  endtask

  // Assertion failures in the bound checker end the run here
  initial begin
    forever begin
      @(negedge aclk);
      if (DUT.u_sva.failed) begin
        abort_run("An assertion of the bound checker failed");
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin
    int         d0;
    int         d1;
    int         port;
    port_side_e side;
    logic [NUM_PORTS-1:0] touched;

    void'($urandom(50));
    inject_global_reset = 1'b1;
    req_valid           = 1'b0;
    req                 = '0;
    done_seen           = '0;
    touched             = '0;

    // Global reset, then every port comes up high
    repeat (RESET_CYCLES) @(posedge aclk);
    #(DRIVE_DELAY);
    inject_global_reset = 1'b0;
    idle(3);

    // Single master pulse
    port      = int'($urandom_range(3, 0));
    d0        = int'($urandom_range(12, 1));
    done_seen = '0;
    send_req(SIDE_MASTER, port, d0);
    wait_done(port_mask(SIDE_MASTER, port), 20);
    idle(2);

    // Overlapping master and slave pulses
    d0        = int'($urandom_range(12, 1));
    d1        = int'($urandom_range(12, 1));
    done_seen = '0;
    send_req(SIDE_MASTER, 1, d0);
    send_req(SIDE_SLAVE, 2, d1);
    wait_done(port_mask(SIDE_MASTER, 1) | port_mask(SIDE_SLAVE, 2), 30);
    idle(2);

    // Dropped requests leave all outputs alone
    send_req(SIDE_MASTER, 2, 0);
    send_req(SIDE_MASTER, 4, 5);
    send_req(SIDE_SLAVE, 9, 3);
    send_req(SIDE_SLAVE, 15, 7);
    idle(8);

    // Restart while still counting, only one done expected
    done_seen = '0;
    send_req(SIDE_SLAVE, 1, 10);
    idle(4);
    send_req(SIDE_SLAVE, 1, 6);
    wait_done(port_mask(SIDE_SLAVE, 1), 30);
    idle(4);

    // Random burst over both sides, reloads may occur
    done_seen = '0;
    for (int i = 0; i < 6; i++) begin
      side    = port_side_e'($urandom_range(1, 0));
      port    = int'($urandom_range(3, 0));
      d0      = int'($urandom_range(12, 1));
      touched = touched | port_mask(side, port);
      send_req(side, port, d0);
      idle(int'($urandom_range(2, 0)));
    end
    wait_done(touched, 40);
    idle(2);

    // Global reset in the middle of a pulse clears it
    send_req(SIDE_MASTER, 3, 12);
    idle(4);
    apply_reset(3);
    idle(20);

    if (!DUT.u_sva.failed) begin
      $display("All checks passed");
      $finish;
    end else begin
      abort_run("Assertion failures were recorded during the run");
    end
  end

endmodule : tb_axi_reset_manager

/* list.f */
design/axi_fabric_pkg.sv
design/rst_ctrl_pkg.sv
design/rst_request_capture.sv
design/rst_port_timer.sv
design/rst_output_stage.sv
design/axi_reset_manager.sv
sim/axi_reset_manager_sva.sv
sim/tb_clock_gen.sv
sim/tb_axi_reset_manager.sv

/* Makefile */
# Verilator build and run of the AXI reset manager testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_axi_reset_manager \
		-f list.f -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb +verilator+error+limit+100

clean:
	rm -rf obj_dir
